/* verilog/rob_pkg.sv */
// shared widths, enums and packed structs for rob allocation, write-back and commit
`default_nettype none

package rob_pkg;

  // ==================================================
  // sizes
  // ==================================================
  localparam int rob_depth_c    = 16;
  localparam int decode_width_c = 2;
  localparam int commit_width_c = 2;
  localparam int idx_w          = $clog2(rob_depth_c);

  // fixed exception entry point
  localparam logic [31:0] trap_vector_c = 32'h0000_1c00;

  typedef logic [31:0]      pc_t;
  typedef logic [idx_w-1:0] rob_idx_t;
  typedef logic [4:0]       arch_reg_t;
  typedef logic [5:0]       phy_reg_t;

  typedef enum logic [1:0] {
    alu    = 2'd0,
    branch = 2'd1,
    mem    = 2'd2,
    priv   = 2'd3
  } instr_type_e;

  typedef enum logic [1:0] {
    load   = 2'd0,
    store  = 2'd1,
    atomic = 2'd2
  } mem_op_e;

  typedef struct packed {
    logic       valid;
    logic [5:0] code;
  } excp_t;

  // ==================================================
  // allocation from rename
  // ==================================================
  // slot 1 is only valid together with slot 0
  typedef struct packed {
    logic                                  ready;
    logic [decode_width_c-1:0]             valid;
    pc_t [decode_width_c-1:0]              pc;
    instr_type_e [decode_width_c-1:0]      instr_type;
    arch_reg_t [decode_width_c-1:0]        arch_reg;
    phy_reg_t [decode_width_c-1:0]         phy_reg;
    phy_reg_t [decode_width_c-1:0]         old_phy_reg;
    excp_t [decode_width_c-1:0]            excp;
  } rob_alloc_req_t;

  typedef struct packed {
    logic                          ready;
    rob_idx_t [decode_width_c-1:0] rob_idx;
    logic [decode_width_c-1:0]     position_bit;
  } rob_alloc_rsp_t;

  // ==================================================
  // write-back
  // ==================================================
  // base sits first in every write-back struct, valid first in base
  typedef struct packed {
    logic        valid;
    rob_idx_t    rob_idx;
    logic        we;
    logic [31:0] wdata;
  } wb_base_t;

  typedef struct packed {
    wb_base_t base;
    logic     br_redirect;
    pc_t      br_target;
  } alu_wb_t;

  typedef struct packed {
    wb_base_t base;
    mem_op_e  mem_op;
    excp_t    excp;
    pc_t      vaddr;
  } mem_wb_t;

  typedef struct packed {
    wb_base_t base;
    logic     priv_changes_state;
    pc_t      br_target;
  } misc_wb_t;

  // ==================================================
  // entries and commit
  // ==================================================
  typedef struct packed {
    logic        complete;
    pc_t         pc;
    instr_type_e instr_type;
    arch_reg_t   arch_reg;
    phy_reg_t    phy_reg;
    phy_reg_t    old_phy_reg;
    excp_t       excp;
    logic        br_redirect;
    pc_t         br_target;
    logic        priv_flush;
  } rob_entry_t;

  typedef struct packed {
    logic [commit_width_c-1:0]       valid;
    rob_entry_t [commit_width_c-1:0] entry;
  } rob_commit_t;

endpackage

`default_nettype wire

/* verilog/wb_stage.sv */
// one-entry write-back holding register between an execution unit and the rob
`timescale 1ns/1ps
`default_nettype none

module wb_stage #(
  parameter type payload_t = rob_pkg::alu_wb_t
) (
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire logic     flush,
  input  wire payload_t in_data,
  output logic          in_ready,
  output payload_t      out_data,
  input  wire logic     out_ready
);

  logic     full;
  payload_t held;

  // free slot, or the held entry leaves this cycle
  assign in_ready = ~full | out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (flush) begin
      // younger results die with the pipeline
      full <= 1'b0;
    end else if (in_ready) begin
      full <= in_data.base.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_ready && in_data.base.valid) begin
      held <= in_data;
    end
  end

  // valid follows the occupancy flag, not the stored copy
  always_comb begin
    out_data            = held;
    out_data.base.valid = full;
  end

endmodule

`default_nettype wire

/* verilog/reorder_buffer.sv */
// reorder buffer: entry store, allocation pointers, write-back acceptance, commit selection
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
  parameter int rob_depth = rob_pkg::rob_depth_c
) (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic                      flush,
  input  wire rob_pkg::rob_alloc_req_t   alloc_req,
  output rob_pkg::rob_alloc_rsp_t        alloc_rsp,
  input  wire rob_pkg::alu_wb_t [1:0]    alu_wb,
  input  wire rob_pkg::mem_wb_t          mem_wb,
  input  wire rob_pkg::misc_wb_t         misc_wb,
  output logic [1:0]                     alu_wb_ready,
  output logic                           mem_wb_ready,
  output logic                           misc_wb_ready,
  output rob_pkg::rob_commit_t           commit
);

  // depth is a power of two, so index arithmetic wraps by itself
  localparam int idx_bits = $clog2(rob_depth);
  localparam int ptr_bits = idx_bits + 1;

  // ==================================================
  // state
  // ==================================================
  rob_pkg::rob_entry_t entries [rob_depth];

  // pointers carry a wrap bit on top of the index
  logic [ptr_bits-1:0] head_ptr;
  logic [ptr_bits-1:0] tail_ptr;
  logic [ptr_bits-1:0] count;

  logic                                 alloc_fire;
  logic [1:0]                           alloc_cnt;
  logic [1:0][ptr_bits-1:0]             alloc_ptr;
  logic [1:0][idx_bits-1:0]             alloc_idx;
  rob_pkg::rob_entry_t [1:0]            alloc_entry;

  logic [1:0][idx_bits-1:0]             alu_idx;
  logic [idx_bits-1:0]                  mem_idx;
  logic [idx_bits-1:0]                  misc_idx;

  logic [idx_bits-1:0]                  head_idx;
  logic [idx_bits-1:0]                  next_idx;
  rob_pkg::rob_entry_t                  head_e;
  rob_pkg::rob_entry_t                  next_e;
  logic                                 group_ok;
  logic [1:0]                           cmt_valid;
  logic [1:0]                           cmt_cnt;

  // ==================================================
  // allocation
  // ==================================================
  // ready looks only at registered occupancy
  assign alloc_rsp.ready = (count <= ptr_bits'(rob_depth - rob_pkg::decode_width_c));
  assign alloc_fire      = alloc_req.ready & alloc_rsp.ready;
  assign alloc_cnt       = alloc_fire ?
                           ({1'b0, alloc_req.valid[0]} + {1'b0, alloc_req.valid[1]}) : 2'd0;

  always_comb begin
    for (int i = 0; i < rob_pkg::decode_width_c; i++) begin
      alloc_ptr[i] = tail_ptr + ptr_bits'(i);
      alloc_idx[i] = alloc_ptr[i][idx_bits-1:0];

      alloc_rsp.rob_idx[i]      = rob_pkg::rob_idx_t'(alloc_idx[i]);
      alloc_rsp.position_bit[i] = alloc_ptr[i][idx_bits];

      // an instruction that already faulted needs no execution
      alloc_entry[i]             = '0;
      alloc_entry[i].complete    = alloc_req.excp[i].valid;
      alloc_entry[i].pc          = alloc_req.pc[i];
      alloc_entry[i].instr_type  = alloc_req.instr_type[i];
      alloc_entry[i].arch_reg    = alloc_req.arch_reg[i];
      alloc_entry[i].phy_reg     = alloc_req.phy_reg[i];
      alloc_entry[i].old_phy_reg = alloc_req.old_phy_reg[i];
      alloc_entry[i].excp        = alloc_req.excp[i];
    end
  end

  // ==================================================
  // write-back acceptance
  // ==================================================
  assign head_idx = head_ptr[idx_bits-1:0];
  assign next_idx = head_idx + 1'b1;

  assign alu_idx[0] = alu_wb[0].base.rob_idx[idx_bits-1:0];
  assign alu_idx[1] = alu_wb[1].base.rob_idx[idx_bits-1:0];
  assign mem_idx    = mem_wb.base.rob_idx[idx_bits-1:0];
  assign misc_idx   = misc_wb.base.rob_idx[idx_bits-1:0];

  // alu results never wait
  assign alu_wb_ready = 2'b11;

  // stores and atomics touch memory, so only from the head
  assign mem_wb_ready  = (mem_wb.mem_op == rob_pkg::load) | (mem_idx == head_idx);
  // same for privileged ops that change machine state
  assign misc_wb_ready = ~misc_wb.priv_changes_state | (misc_idx == head_idx);

  always_ff @(posedge clk) begin
    for (int i = 0; i < rob_pkg::decode_width_c; i++) begin
      if (alloc_fire && alloc_req.valid[i]) begin
        entries[alloc_idx[i]] <= alloc_entry[i];
      end
    end

    for (int i = 0; i < 2; i++) begin
      if (alu_wb[i].base.valid && alu_wb_ready[i]) begin
        entries[alu_idx[i]].complete    <= 1'b1;
        entries[alu_idx[i]].br_redirect <= alu_wb[i].br_redirect;
        entries[alu_idx[i]].br_target   <= alu_wb[i].br_target;
      end
    end

    if (mem_wb.base.valid && mem_wb_ready) begin
      entries[mem_idx].complete <= 1'b1;
      entries[mem_idx].excp     <= mem_wb.excp;
    end

    if (misc_wb.base.valid && misc_wb_ready) begin
      entries[misc_idx].complete    <= 1'b1;
      entries[misc_idx].priv_flush  <= misc_wb.priv_changes_state;
      entries[misc_idx].br_target   <= misc_wb.br_target;
      entries[misc_idx].br_redirect <= 1'b0;
    end
  end

  // ==================================================
  // commit selection
  // ==================================================
  assign head_e = entries[head_idx];
  assign next_e = entries[next_idx];

  // second slot masks: redirect, exception, one branch, priv
  assign group_ok = ~head_e.br_redirect & ~next_e.br_redirect &
                    ~head_e.excp.valid & ~next_e.excp.valid &
                    (head_e.instr_type != rob_pkg::branch) &
                    (head_e.instr_type != rob_pkg::priv);

  // nothing retires while the flush pulse is out
  assign cmt_valid[0] = ~flush & (count > 0) & head_e.complete;
  assign cmt_valid[1] = cmt_valid[0] & (count > 1) & next_e.complete & group_ok;
  assign cmt_cnt      = {1'b0, cmt_valid[0]} + {1'b0, cmt_valid[1]};

  assign commit.valid    = cmt_valid;
  assign commit.entry[0] = head_e;
  assign commit.entry[1] = next_e;

  // ==================================================
  // pointers and occupancy
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
    end else if (flush) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
    end else begin
      head_ptr <= head_ptr + ptr_bits'(cmt_cnt);
      tail_ptr <= tail_ptr + ptr_bits'(alloc_cnt);
      count    <= count + ptr_bits'(alloc_cnt) - ptr_bits'(cmt_cnt);
    end
  end

endmodule

`default_nettype wire

/* verilog/commit_ctrl.sv */
// commit controller: registered flush, redirect target and retired instruction count
`timescale 1ns/1ps
`default_nettype none

module commit_ctrl (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire rob_pkg::rob_commit_t  commit,
  output logic                       flush,
  output rob_pkg::pc_t               redirect_pc,
  output logic [15:0]                retired_count
);

  logic         redirect_hit;
  rob_pkg::pc_t redirect_target;
  logic [1:0]   retire_cnt;

  // ==================================================
  // redirect source
  // ==================================================
  // walk youngest to oldest, so the oldest hit is the one kept
  always_comb begin
    redirect_hit    = 1'b0;
    redirect_target = '0;
    for (int i = rob_pkg::commit_width_c - 1; i >= 0; i--) begin
      if (commit.valid[i]) begin
        if (commit.entry[i].excp.valid) begin
          redirect_hit    = 1'b1;
          redirect_target = rob_pkg::trap_vector_c;
        end else if (commit.entry[i].br_redirect) begin
          redirect_hit    = 1'b1;
          redirect_target = commit.entry[i].br_target;
        end else if (commit.entry[i].priv_flush) begin
          // resume right after the privileged op
          redirect_hit    = 1'b1;
          redirect_target = commit.entry[i].pc + 32'd4;
        end
      end
    end
  end

  // the redirecting instruction itself counts as retired
  assign retire_cnt = {1'b0, commit.valid[0]} + {1'b0, commit.valid[1]};

  // ==================================================
  // registers
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flush         <= 1'b0;
      retired_count <= '0;
    end else begin
      // one-cycle pulse per redirecting commit
      flush         <= redirect_hit;
      retired_count <= retired_count + 16'(retire_cnt);
    end
  end

  always_ff @(posedge clk) begin
    if (redirect_hit) begin
      redirect_pc <= redirect_target;
    end
  end

endmodule

`default_nettype wire

/* verilog/rob_backend_top.sv */
// retirement back end: write-back stages, reorder buffer and commit controller
`timescale 1ns/1ps
`default_nettype none

module rob_backend_top #(
  parameter int rob_depth = rob_pkg::rob_depth_c
) (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire rob_pkg::rob_alloc_req_t  alloc_req,
  output rob_pkg::rob_alloc_rsp_t       alloc_rsp,
  input  wire rob_pkg::alu_wb_t         alu0_wb,
  input  wire rob_pkg::alu_wb_t         alu1_wb,
  input  wire rob_pkg::mem_wb_t         mem_wb,
  input  wire rob_pkg::misc_wb_t        misc_wb,
  output logic                          alu0_ready,
  output logic                          alu1_ready,
  output logic                          mem_ready,
  output logic                          misc_ready,
  output rob_pkg::rob_commit_t          commit,
  output logic                          flush,
  output rob_pkg::pc_t                  redirect_pc,
  output logic [15:0]                   retired_count
);

  // stage outputs toward the buffer, and its per-port answers
  rob_pkg::alu_wb_t [1:0] alu_held;
  rob_pkg::mem_wb_t       mem_held;
  rob_pkg::misc_wb_t      misc_held;
  logic [1:0]             alu_held_ready;
  logic                   mem_held_ready;
  logic                   misc_held_ready;

  // ==================================================
  // write-back stages
  // ==================================================
  wb_stage #(.payload_t(rob_pkg::alu_wb_t)) alu0_stage_i (
    .clk(clk), .rst_n(rst_n), .flush(flush),
    .in_data(alu0_wb), .in_ready(alu0_ready),
    .out_data(alu_held[0]), .out_ready(alu_held_ready[0])
  );

  wb_stage #(.payload_t(rob_pkg::alu_wb_t)) alu1_stage_i (
    .clk(clk), .rst_n(rst_n), .flush(flush),
    .in_data(alu1_wb), .in_ready(alu1_ready),
    .out_data(alu_held[1]), .out_ready(alu_held_ready[1])
  );

  wb_stage #(.payload_t(rob_pkg::mem_wb_t)) mem_stage_i (
    .clk(clk), .rst_n(rst_n), .flush(flush),
    .in_data(mem_wb), .in_ready(mem_ready),
    .out_data(mem_held), .out_ready(mem_held_ready)
  );

  wb_stage #(.payload_t(rob_pkg::misc_wb_t)) misc_stage_i (
    .clk(clk), .rst_n(rst_n), .flush(flush),
    .in_data(misc_wb), .in_ready(misc_ready),
    .out_data(misc_held), .out_ready(misc_held_ready)
  );

  // ==================================================
  // buffer and commit
  // ==================================================
  reorder_buffer #(.rob_depth(rob_depth)) rob_i (
    .clk(clk), .rst_n(rst_n), .flush(flush),
    .alloc_req(alloc_req), .alloc_rsp(alloc_rsp),
    .alu_wb(alu_held), .mem_wb(mem_held), .misc_wb(misc_held),
    .alu_wb_ready(alu_held_ready), .mem_wb_ready(mem_held_ready),
    .misc_wb_ready(misc_held_ready),
    .commit(commit)
  );

  // flush feeds back into the buffer and every stage
  commit_ctrl commit_ctrl_i (
    .clk(clk), .rst_n(rst_n),
    .commit(commit),
    .flush(flush), .redirect_pc(redirect_pc),
    .retired_count(retired_count)
  );

endmodule

`default_nettype wire

/* bench/rob_vectors.svh */
// stimulus and expected-value rows for the rob back-end testbench
`ifndef ROB_VECTORS_SVH
`define ROB_VECTORS_SVH

typedef struct {
  int reps;
  int av;
  int at;
  int ax;
  int wv;
  int a0;
  int a1;
  int ms;
  int mc;
  int flg;
  int tgt;
  int ck;
  int ev;
  int epc;
  int ecnt;
} vec_t;

localparam int num_vec = 49;

// columns: reps, alloc valid, alloc types {t1,t0}, alloc excp, wb valid {misc,mem,alu1,alu0},
// alu0 seq, alu1 seq, mem seq, misc seq, flags {pstate,store,redir1,redir0}, branch target,
// checks {count,flush,mem_ready,ready}, expected {flush,mem_ready,ready}, redirect pc, retired
vec_t vectors [num_vec] = '{
  '{1, 'b11, 'h0, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{1, 'b11, 'h0, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{1, 'b00, 'h0, 'b00, 'b0011,  3,  1,  0,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{1, 'b00, 'h0, 'b00, 'b0101,  0,  0,  2,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{3, 'b00, 'h0, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{1, 'b00, 'h0, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b1000, 'b000, 'h0000,  4},
  // fill up to fifteen entries
  '{7, 'b11, 'h0, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{1, 'b01, 'h0, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b0001, 'b001, 'h0000,  0},
  '{1, 'b11, 'h0, 'b00, 'b0011,  4,  5,  0,  0, 'b0000, 'h0000, 'b0001, 'b000, 'h0000,  0},
  '{1, 'b00, 'h0, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{1, 'b00, 'h0, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b0001, 'b000, 'h0000,  0},
  '{1, 'b00, 'h0, 'b00, 'b0011,  6,  7,  0,  0, 'b0000, 'h0000, 'b0001, 'b001, 'h0000,  0},
  '{1, 'b00, 'h0, 'b00, 'b0011,  8,  9,  0,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{1, 'b00, 'h0, 'b00, 'b0011, 10, 11,  0,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{1, 'b00, 'h0, 'b00, 'b0011, 12, 13,  0,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{1, 'b00, 'h0, 'b00, 'b0011, 14, 15,  0,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{1, 'b00, 'h0, 'b00, 'b0011, 16, 17,  0,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{1, 'b00, 'h0, 'b00, 'b0001, 18,  0,  0,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{2, 'b00, 'h0, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{1, 'b00, 'h0, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b1000, 'b000, 'h0000, 19},
  // store behind an older alu op
  '{1, 'b11, 'h8, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{1, 'b11, 'hA, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{1, 'b00, 'h0, 'b00, 'b0100,  0,  0, 20,  0, 'b0100, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{1, 'b00, 'h0, 'b00, 'b0001, 19,  0,  0,  0, 'b0000, 'h0000, 'b0010, 'b000, 'h0000,  0},
  '{2, 'b00, 'h0, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b0010, 'b000, 'h0000,  0},
  '{1, 'b00, 'h0, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b0010, 'b010, 'h0000,  0},
  '{1, 'b00, 'h0, 'b00, 'b0100,  0,  0, 21,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{1, 'b00, 'h0, 'b00, 'b0100,  0,  0, 22,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{2, 'b00, 'h0, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{1, 'b00, 'h0, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b1000, 'b000, 'h0000, 23},
  // two plain branches, then a redirecting one
  '{1, 'b11, 'h5, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{1, 'b00, 'h0, 'b00, 'b0011, 23, 24,  0,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{3, 'b00, 'h0, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{1, 'b11, 'h1, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{1, 'b11, 'h0, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{1, 'b00, 'h0, 'b00, 'b0011, 26, 27,  0,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{1, 'b00, 'h0, 'b00, 'b0011, 25, 28,  0,  0, 'b0001, 'h2400, 'b0000, 'b000, 'h0000,  0},
  '{2, 'b00, 'h0, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{1, 'b00, 'h0, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b0100, 'b100, 'h2400,  0},
  '{1, 'b00, 'h0, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b0100, 'b000, 'h0000,  0},
  // exception at allocation, then a state-changing priv op
  '{1, 'b11, 'h0, 'b01, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{1, 'b00, 'h0, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{1, 'b00, 'h0, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b0100, 'b100, 'h1c00,  0},
  '{1, 'b00, 'h0, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b0100, 'b000, 'h0000,  0},
  '{1, 'b11, 'h3, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{1, 'b00, 'h0, 'b00, 'b1000,  0,  0,  0, 31, 'b1000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{2, 'b00, 'h0, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b0000, 'b000, 'h0000,  0},
  '{1, 'b00, 'h0, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b0100, 'b100, 'h8080,  0},
  '{1, 'b00, 'h0, 'b00, 'b0000,  0,  0,  0,  0, 'b0000, 'h0000, 'b1100, 'b000, 'h0000, 28}
};

`endif

/* bench/rob_tb.sv */
// rob back-end testbench with clock, reset, vector loop, commit-order model and timeout
`timescale 1ns/1ps
`default_nettype none

module rob_tb;

  localparam int rob_depth = rob_pkg::rob_depth_c;
  localparam int max_seq   = 64;

  logic                    clk;
  logic                    rst_n;
  rob_pkg::rob_alloc_req_t alloc_req;
  rob_pkg::rob_alloc_rsp_t alloc_rsp;
  rob_pkg::alu_wb_t        alu0_wb;
  rob_pkg::alu_wb_t        alu1_wb;
  rob_pkg::mem_wb_t        mem_wb;
  rob_pkg::misc_wb_t       misc_wb;
  logic                    alu0_ready;
  logic                    alu1_ready;
  logic                    mem_ready;
  logic                    misc_ready;
  rob_pkg::rob_commit_t    commit;
  logic                    flush;
  rob_pkg::pc_t            redirect_pc;
  logic [15:0]             retired_count;

  `include "rob_vectors.svh"

  // ==================================================
  // reference model state, indexed by program order
  // ==================================================
  int                        seq_q [$];
  logic [rob_pkg::idx_w-1:0] idx_of [max_seq];
  logic [1:0]                type_of [max_seq];
  logic                      stops_group [max_seq];
  logic                      causes_flush [max_seq];
  logic [31:0]               target_of [max_seq];
  int                        next_seq;
  int                        model_retired;
  int                        cycles;
  int                        limit;
  logic                      pend_flush;
  logic [31:0]               pend_pc;
  logic [31:0]               lcg_state;

  rob_backend_top #(.rob_depth(rob_depth)) rob_backend_top_i (
    .clk(clk), .rst_n(rst_n),
    .alloc_req(alloc_req), .alloc_rsp(alloc_rsp),
    .alu0_wb(alu0_wb), .alu1_wb(alu1_wb), .mem_wb(mem_wb), .misc_wb(misc_wb),
    .alu0_ready(alu0_ready), .alu1_ready(alu1_ready),
    .mem_ready(mem_ready), .misc_ready(misc_ready),
    .commit(commit), .flush(flush), .redirect_pc(redirect_pc),
    .retired_count(retired_count)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles > limit) begin
      fail_run("timeout: the vector loop ran past its cycle limit");
    end
  end

  function automatic logic [31:0] pc_of(input int seq);
    return 32'h0000_8000 + 32'(seq) * 32'd4;
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
      fail_run("stopping at the first mismatch");
    end
  endtask

  task automatic build_alu(input int seq, input logic redir, input logic [31:0] tgt,
                           output rob_pkg::alu_wb_t wb);
    wb                  = '0;
    wb.base.valid       = 1'b1;
    wb.base.rob_idx     = idx_of[seq];
    wb.base.we          = 1'b1;
    wb.base.wdata       = 32'(seq);
    wb.br_redirect      = redir;
    wb.br_target        = tgt;
    if (redir) begin
      stops_group[seq]  = 1'b1;
      causes_flush[seq] = 1'b1;
      target_of[seq]    = tgt;
    end
  endtask

  // ==================================================
  // drive one row
  // ==================================================
  task automatic drive_row(input vec_t v);
    rob_pkg::alu_wb_t a0;
    rob_pkg::alu_wb_t a1;
    alloc_req       = '0;
    alloc_req.ready = |v.av[1:0];
    for (int i = 0; i < 2; i++) begin
      alloc_req.valid[i]        = v.av[i];
      alloc_req.pc[i]           = pc_of(next_seq + i);
      alloc_req.instr_type[i]   = rob_pkg::instr_type_e'(v.at[2*i +: 2]);
      alloc_req.arch_reg[i]     = 5'(next_seq + i);
      alloc_req.phy_reg[i]      = 6'(next_seq + i + 32);
      alloc_req.old_phy_reg[i]  = 6'(next_seq + i);
      alloc_req.excp[i].valid   = v.ax[i];
      alloc_req.excp[i].code    = v.ax[i] ? 6'h08 : 6'h00;
    end
    a0 = '0;
    a1 = '0;
    if (v.wv[0]) build_alu(v.a0, v.flg[0], v.tgt, a0);
    if (v.wv[1]) build_alu(v.a1, v.flg[1], v.tgt, a1);
    // shuffle which alu port carries which result
    lcg_state = lcg_next(lcg_state);
    alu0_wb   = lcg_state[16] ? a1 : a0;
    alu1_wb   = lcg_state[16] ? a0 : a1;
    mem_wb = '0;
    if (v.wv[2]) begin
      mem_wb.base.valid   = 1'b1;
      mem_wb.base.rob_idx = idx_of[v.ms];
      mem_wb.base.wdata   = 32'(v.ms);
      mem_wb.mem_op       = v.flg[2] ? rob_pkg::store : rob_pkg::load;
      mem_wb.vaddr        = 32'h0000_0100 + 32'(v.ms);
    end
    misc_wb = '0;
    if (v.wv[3]) begin
      misc_wb.base.valid         = 1'b1;
      misc_wb.base.rob_idx       = idx_of[v.mc];
      misc_wb.priv_changes_state = v.flg[3];
      if (v.flg[3]) begin
        causes_flush[v.mc] = 1'b1;
        target_of[v.mc]    = pc_of(v.mc) + 32'd4;
      end
    end
  endtask

  // ==================================================
  // compare one cycle against the model
  // ==================================================
  task automatic check_cycle(input vec_t v);
    int s;
    int first;
    first = 0;
    check_value("retired_count", retired_count, model_retired);
    check_value("flush", flush, pend_flush);
    if (pend_flush) check_value("redirect_pc", redirect_pc, pend_pc);
    if (v.ck[0]) check_value("alloc_rsp.ready", alloc_rsp.ready, v.ev[0]);
    if (v.ck[1]) check_value("mem_ready", mem_ready, v.ev[1]);
    if (v.ck[2]) begin
      check_value("flush", flush, v.ev[2]);
      if (v.ev[2]) check_value("redirect_pc", redirect_pc, v.epc);
    end
    if (v.ck[3]) check_value("retired_count", retired_count, v.ecnt);
    // younger work is discarded
    if (flush) seq_q.delete();
    pend_flush = 1'b0;
    for (int i = 0; i < 2; i++) begin
      if (commit.valid[i]) begin
        if (seq_q.size() == 0) fail_run("a commit slot is valid with nothing outstanding");
        s = seq_q.pop_front();
        check_value($sformatf("commit.entry[%0d].pc", i), commit.entry[i].pc, pc_of(s));
        if (i == 0) first = s;
        if (i == 1 && (type_of[first] == rob_pkg::branch || type_of[first] == rob_pkg::priv ||
                       stops_group[first] || stops_group[s])) begin
          fail_run("two instructions retired together across a branch, priv op or redirect");
        end
        model_retired++;
        if (causes_flush[s] && !pend_flush) begin
          pend_flush = 1'b1;
          pend_pc    = target_of[s];
        end
      end
    end
    if (alloc_req.ready && alloc_rsp.ready) begin
      for (int i = 0; i < 2; i++) begin
        if (alloc_req.valid[i]) begin
          idx_of[next_seq]       = alloc_rsp.rob_idx[i];
          type_of[next_seq]      = alloc_req.instr_type[i];
          stops_group[next_seq]  = alloc_req.excp[i].valid;
          causes_flush[next_seq] = alloc_req.excp[i].valid;
          target_of[next_seq]    = rob_pkg::trap_vector_c;
          seq_q.push_back(next_seq);
          next_seq++;
        end
      end
    end
  endtask

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    alloc_req     = '0;
    alu0_wb       = '0;
    alu1_wb       = '0;
    mem_wb        = '0;
    misc_wb       = '0;
    next_seq      = 0;
    model_retired = 0;
    cycles        = 0;
    pend_flush    = 1'b0;
    pend_pc       = '0;
    lcg_state     = 32'h2737;
    for (int s = 0; s < max_seq; s++) begin
      idx_of[s]       = '0;
      type_of[s]      = '0;
      stops_group[s]  = 1'b0;
      causes_flush[s] = 1'b0;
      target_of[s]    = '0;
    end
    limit = 50;
    for (int r = 0; r < num_vec; r++) limit += vectors[r].reps * 4;

    repeat (2) @(posedge clk);
    #2 rst_n = 1'b1;
    @(negedge clk);
    // state straight out of reset
    check_value("commit.valid", commit.valid, 0);
    check_value("flush", flush, 0);
    check_value("alloc_rsp.ready", alloc_rsp.ready, 1);
    check_value("alloc_rsp.rob_idx[0]", alloc_rsp.rob_idx[0], 0);
    check_value("alloc_rsp.rob_idx[1]", alloc_rsp.rob_idx[1], 1);
    check_value("alloc_rsp.position_bit", alloc_rsp.position_bit, 0);
    check_value("stage ready", {alu0_ready, alu1_ready, mem_ready, misc_ready}, 4'hf);

    for (int r = 0; r < num_vec; r++) begin
      for (int k = 0; k < vectors[r].reps; k++) begin
        @(posedge clk);
        #2;
        drive_row(vectors[r]);
        @(negedge clk);
        check_cycle(vectors[r]);
      end
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+bench
verilog/rob_pkg.sv
verilog/wb_stage.sv
verilog/reorder_buffer.sv
verilog/commit_ctrl.sv
verilog/rob_backend_top.sv
bench/rob_tb.sv
